/* mem_pkg.sv */
package mem_pkg;

	///////////////////////////////////////////////////////////////////////
	// Processor memory bus
	///////////////////////////////////////////////////////////////////////

	// Address width, one word per address
	localparam int ADDR_W = 8;	// 256 words of backing store

	// Data width of the accumulator word
	localparam int DATA_W = 8;

	// Word address as issued by the client and held as cache tag
	typedef logic [ADDR_W-1:0] addr_t;

	// Data word moved between client, cache entries and RAM
	typedef logic [DATA_W-1:0] data_t;

endpackage

/* cache_pkg.sv */
package cache_pkg;

	///////////////////////////////////////////////////////////////////////
	// Cache access and controller encodings
	///////////////////////////////////////////////////////////////////////

	// Kind of client access
	typedef logic access_t;

	localparam access_t ACC_READ  = 1'b0;	// Return cached word
	localparam access_t ACC_WRITE = 1'b1;	// Replace word, mark dirty

	// Controller states
	typedef enum logic [2:0] {
		ST_IDLE,		// Waiting for req
		ST_LOOKUP,		// Tag compare across all entries
		ST_WRITEBACK,	// Dirty victim goes back to RAM
		ST_FILL_READ,	// RAM read of target word issued
		ST_FILL_WAIT,	// RAM data returns, victim refilled
		ST_RESPOND		// done pulse, rdata and hit valid
	} ctrl_state_t;

endpackage

/* cache_way.sv */
module cache_way #(
	parameter int N_WAYS = 4,
	parameter int RESET_AGE = 0,
	localparam int AGE_W = $clog2(N_WAYS)
) (
	input  logic clk,
	input  logic reset,
	input  mem_pkg::addr_t lookup_addr,	// Shared compare address
	input  logic fill,						// Load tag and data from RAM
	input  logic write,						// Client write into this entry
	input  logic touch,						// Make this entry most recent
	input  mem_pkg::addr_t fill_addr,
	input  mem_pkg::data_t fill_data,
	input  mem_pkg::data_t write_data,
	input  logic [AGE_W-1:0] touch_age,	// Old age of the touched entry
	output logic match,
	output logic [AGE_W-1:0] age,
	output mem_pkg::addr_t tag,
	output mem_pkg::data_t data,
	output logic valid,
	output logic dirty
);

	// Most recently used age
	localparam logic [AGE_W-1:0] AGE_MRU = AGE_W'(N_WAYS - 1);

	// Hit detect for this entry
	assign match = valid && (tag == lookup_addr);

	///////////////////////////////////////////////////////////////////////
	// Entry flags and recency
	///////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= 1'b0;
			dirty <= 1'b0;
			age   <= AGE_W'(RESET_AGE);	// Distinct start ages form a permutation
		end else begin
			if (fill) begin
				valid <= 1'b1;
				dirty <= 1'b0;		// Fresh copy of RAM
			end
			if (write)
				dirty <= 1'b1;		// Write overrides the clean fill

			// Controller parks touch_age at MRU when nothing is touched,
			// so no entry moves then
			if (touch)
				age <= AGE_MRU;
			else if (age > touch_age)
				age <= age - 1'b1;	// Slide down behind the touched entry
		end
	end

	///////////////////////////////////////////////////////////////////////
	// Payload
	///////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (fill)
			tag <= fill_addr;
		if (write)
			data <= write_data;		// Client word wins
		else if (fill)
			data <= fill_data;
	end

endmodule

/* way_select.sv */
module way_select #(
	parameter int N_WAYS = 4,
	localparam int AGE_W = $clog2(N_WAYS)
) (
	input  logic [N_WAYS-1:0] match,
	input  logic [N_WAYS-1:0][AGE_W-1:0] age,
	input  mem_pkg::addr_t [N_WAYS-1:0] tag,
	input  mem_pkg::data_t [N_WAYS-1:0] data,
	input  logic [N_WAYS-1:0] valid,
	input  logic [N_WAYS-1:0] dirty,
	output logic hit,
	output logic [N_WAYS-1:0] hit_onehot,
	output mem_pkg::data_t hit_data,
	output logic [AGE_W-1:0] hit_age,
	output logic [N_WAYS-1:0] victim_onehot,
	output mem_pkg::addr_t victim_tag,
	output mem_pkg::data_t victim_data,
	output logic victim_dirty
);

	///////////////////////////////////////////////////////////////////////
	// Hit side
	///////////////////////////////////////////////////////////////////////

	// Tags are unique, at most one entry matches
	assign hit_onehot = match;
	assign hit        = |match;

	always_comb begin
		hit_data = '0;
		hit_age  = '0;
		for (int i = 0; i < N_WAYS; i++) begin
			if (match[i]) begin
				hit_data = hit_data | data[i];	// AND-OR mux
				hit_age  = hit_age | age[i];
			end
		end
	end

	///////////////////////////////////////////////////////////////////////
	// Victim side
	///////////////////////////////////////////////////////////////////////

	// Ages are a permutation, exactly one entry sits at zero
	always_comb begin
		victim_onehot = '0;
		victim_tag    = '0;
		victim_data   = '0;
		for (int i = 0; i < N_WAYS; i++) begin
			if (age[i] == '0) begin
				victim_onehot[i] = 1'b1;
				victim_tag       = victim_tag | tag[i];
				victim_data      = victim_data | data[i];
			end
		end
	end

	// Invalid entries never need writeback
	assign victim_dirty = |(victim_onehot & valid & dirty);

endmodule

/* cache_ctrl.sv */
module cache_ctrl #(
	parameter int N_WAYS = 4,
	localparam int AGE_W = $clog2(N_WAYS)
) (
	input  logic clk,
	input  logic reset,
	// Client side
	input  logic req,
	input  cache_pkg::access_t rw,
	input  mem_pkg::addr_t addr,
	input  mem_pkg::data_t wdata,
	// From selector
	input  logic hit,
	input  logic [N_WAYS-1:0] hit_onehot,
	input  mem_pkg::data_t hit_data,
	input  logic [AGE_W-1:0] hit_age,
	input  logic [N_WAYS-1:0] victim_onehot,
	input  mem_pkg::addr_t victim_tag,
	input  mem_pkg::data_t victim_data,
	input  logic victim_dirty,
	// From RAM
	input  mem_pkg::data_t ram_rdata,
	// Client response
	output logic busy,
	output logic done,
	output logic resp_hit,
	output mem_pkg::data_t rdata,
	// To entries
	output mem_pkg::addr_t lookup_addr,
	output mem_pkg::addr_t fill_addr,
	output mem_pkg::data_t fill_data,
	output mem_pkg::data_t write_data,
	output logic [AGE_W-1:0] touch_age,
	output logic [N_WAYS-1:0] way_fill,
	output logic [N_WAYS-1:0] way_write,
	output logic [N_WAYS-1:0] way_touch,
	// To RAM
	output logic ram_en,
	output logic ram_we,
	output mem_pkg::addr_t ram_addr,
	output mem_pkg::data_t ram_wdata
);

	localparam logic [AGE_W-1:0] AGE_MRU = AGE_W'(N_WAYS - 1);

	cache_pkg::ctrl_state_t state, state_next;

	cache_pkg::access_t req_rw;		// Latched request
	mem_pkg::addr_t req_addr;
	mem_pkg::data_t req_wdata;
	logic [N_WAYS-1:0] victim_q;	// Victim held across the miss

	logic lookup_hit;				// Hit seen in ST_LOOKUP
	logic is_write;

	assign lookup_hit = (state == cache_pkg::ST_LOOKUP) && hit;
	assign is_write   = (req_rw == cache_pkg::ACC_WRITE);

	///////////////////////////////////////////////////////////////////////
	// State machine
	///////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			state <= cache_pkg::ST_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			cache_pkg::ST_IDLE:
				if (req)
					state_next = cache_pkg::ST_LOOKUP;
			cache_pkg::ST_LOOKUP:
				if (hit)
					state_next = cache_pkg::ST_RESPOND;
				else if (victim_dirty)
					state_next = cache_pkg::ST_WRITEBACK;
				else
					state_next = cache_pkg::ST_FILL_READ;
			cache_pkg::ST_WRITEBACK: state_next = cache_pkg::ST_FILL_READ;
			cache_pkg::ST_FILL_READ: state_next = cache_pkg::ST_FILL_WAIT;
			cache_pkg::ST_FILL_WAIT: state_next = cache_pkg::ST_RESPOND;
			cache_pkg::ST_RESPOND:   state_next = cache_pkg::ST_IDLE;
			default:                 state_next = cache_pkg::ST_IDLE;
		endcase
	end

	///////////////////////////////////////////////////////////////////////
	// Request and response registers
	///////////////////////////////////////////////////////////////////////

	// Request fields sampled on the req edge
	always_ff @(posedge clk) begin
		if (state == cache_pkg::ST_IDLE && req) begin
			req_rw    <= rw;
			req_addr  <= addr;
			req_wdata <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			victim_q <= '0;
			resp_hit <= 1'b0;
		end else if (state == cache_pkg::ST_LOOKUP) begin
			victim_q <= victim_onehot;	// LRU entry at lookup time
			resp_hit <= hit;
		end
	end

	// Read data for the client, writes echo their own word
	always_ff @(posedge clk) begin
		if (lookup_hit)
			rdata <= (req_rw == cache_pkg::ACC_READ) ? hit_data : req_wdata;
		else if (state == cache_pkg::ST_FILL_WAIT)
			rdata <= is_write ? req_wdata : ram_rdata;
	end

	assign busy = (state != cache_pkg::ST_IDLE);
	assign done = (state == cache_pkg::ST_RESPOND);

	///////////////////////////////////////////////////////////////////////
	// Entry strobes
	///////////////////////////////////////////////////////////////////////

	assign lookup_addr = req_addr;
	assign fill_addr   = req_addr;
	assign fill_data   = ram_rdata;		// Refill straight from RAM output
	assign write_data  = req_wdata;

	always_comb begin
		way_touch = '0;
		way_fill  = '0;
		way_write = '0;
		touch_age = AGE_MRU;			// Parked, nothing ages
		if (lookup_hit) begin
			way_touch = hit_onehot;
			touch_age = hit_age;
			if (is_write)
				way_write = hit_onehot;
		end else if (state == cache_pkg::ST_FILL_WAIT) begin
			way_fill  = victim_q;
			way_touch = victim_q;
			touch_age = '0;				// Victim was the oldest
		end else if (state == cache_pkg::ST_RESPOND && !resp_hit && is_write) begin
			way_write = victim_q;		// Merge after the fill
		end
	end

	///////////////////////////////////////////////////////////////////////
	// RAM port
	///////////////////////////////////////////////////////////////////////

	assign ram_en    = (state == cache_pkg::ST_WRITEBACK) || (state == cache_pkg::ST_FILL_READ);
	assign ram_we    = (state == cache_pkg::ST_WRITEBACK);
	assign ram_addr  = ram_we ? victim_tag : req_addr;	// Victim out, target in
	assign ram_wdata = victim_data;

endmodule

/* backing_ram.sv */
module backing_ram (
	input  logic clk,
	input  logic en,
	input  logic we,
	input  mem_pkg::addr_t addr,
	input  mem_pkg::data_t wdata,
	output mem_pkg::data_t rdata
);

	// Whole address space, one word per address
	localparam int DEPTH = 2 ** mem_pkg::ADDR_W;

	mem_pkg::data_t mem [DEPTH];

	///////////////////////////////////////////////////////////////////////
	// Single port, registered read
	///////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];	// Valid the cycle after the read
		end
	end

endmodule

/* cache_top.sv */
module cache_top #(
	parameter int N_WAYS = 4,
	localparam int AGE_W = $clog2(N_WAYS)
) (
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  cache_pkg::access_t rw,
	input  mem_pkg::addr_t addr,
	input  mem_pkg::data_t wdata,
	output logic busy,
	output logic done,
	output logic hit,
	output mem_pkg::data_t rdata
);

	// Controller to entries
	mem_pkg::addr_t lookup_addr, fill_addr;
	mem_pkg::data_t fill_data, write_data;
	logic [AGE_W-1:0] touch_age;
	logic [N_WAYS-1:0] way_fill, way_write, way_touch;

	// Entries to selector
	logic [N_WAYS-1:0] way_match, way_valid, way_dirty;
	logic [N_WAYS-1:0][AGE_W-1:0] way_age;
	mem_pkg::addr_t [N_WAYS-1:0] way_tag;
	mem_pkg::data_t [N_WAYS-1:0] way_data;

	// Selector to controller
	logic sel_hit, victim_dirty;
	logic [N_WAYS-1:0] hit_onehot, victim_onehot;
	logic [AGE_W-1:0] hit_age;
	mem_pkg::data_t hit_data, victim_data;
	mem_pkg::addr_t victim_tag;

	// RAM port
	logic ram_en, ram_we;
	mem_pkg::addr_t ram_addr;
	mem_pkg::data_t ram_wdata, ram_rdata;

	cache_ctrl #(.N_WAYS(N_WAYS)) u_cache_ctrl (
		.clk(clk), .reset(reset), .req(req), .rw(rw), .addr(addr), .wdata(wdata),
		.hit(sel_hit), .hit_onehot(hit_onehot), .hit_data(hit_data), .hit_age(hit_age),
		.victim_onehot(victim_onehot), .victim_tag(victim_tag),
		.victim_data(victim_data), .victim_dirty(victim_dirty), .ram_rdata(ram_rdata),
		.busy(busy), .done(done), .resp_hit(hit), .rdata(rdata),
		.lookup_addr(lookup_addr), .fill_addr(fill_addr), .fill_data(fill_data),
		.write_data(write_data), .touch_age(touch_age), .way_fill(way_fill),
		.way_write(way_write), .way_touch(way_touch), .ram_en(ram_en), .ram_we(ram_we),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata)
	);

	// Entry array, start ages follow the index
	for (genvar i = 0; i < N_WAYS; i++) begin : g_way
		cache_way #(.N_WAYS(N_WAYS), .RESET_AGE(i)) u_cache_way (
			.clk(clk), .reset(reset), .lookup_addr(lookup_addr),
			.fill(way_fill[i]), .write(way_write[i]), .touch(way_touch[i]),
			.fill_addr(fill_addr), .fill_data(fill_data), .write_data(write_data),
			.touch_age(touch_age), .match(way_match[i]), .age(way_age[i]),
			.tag(way_tag[i]), .data(way_data[i]), .valid(way_valid[i]), .dirty(way_dirty[i])
		);
	end

	way_select #(.N_WAYS(N_WAYS)) u_way_select (
		.match(way_match), .age(way_age), .tag(way_tag), .data(way_data),
		.valid(way_valid), .dirty(way_dirty), .hit(sel_hit), .hit_onehot(hit_onehot),
		.hit_data(hit_data), .hit_age(hit_age), .victim_onehot(victim_onehot),
		.victim_tag(victim_tag), .victim_data(victim_data), .victim_dirty(victim_dirty)
	);

	backing_ram u_backing_ram (
		.clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(ram_rdata)
	);

endmodule

/* cache_assert.sv */
module cache_assert #(
	parameter int N_WAYS = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic busy,
	input  logic done,
	input  logic [N_WAYS-1:0] hit_onehot,	// Selector hit vector
	input  logic victim_dirty,				// Selector flag of the LRU entry
	input  logic ram_we,
	input  cache_pkg::ctrl_state_t state		// Controller FSM state
);

	// Request accepted and not yet answered
	logic pending;

	always_ff @(posedge clk) begin
		if (reset)
			pending <= 1'b0;
		else if (req && !busy)
			pending <= 1'b1;
		else if (done)
			pending <= 1'b0;	// Closed by its single done cycle
	end

	///////////////////////////////////////////////////////////////////////
	// Client protocol
	///////////////////////////////////////////////////////////////////////

	// One done per accepted request, a second done cycle finds nothing open
	done_pulse: assert property (@(posedge clk) disable iff (reset) done |-> pending)
		else $error("done without an open request or longer than one cycle");

	// No back-pressure, client must wait for busy low
	req_idle: assert property (@(posedge clk) disable iff (reset) busy |-> !req)
		else $error("req pulsed while busy");

	///////////////////////////////////////////////////////////////////////
	// Selector and RAM port
	///////////////////////////////////////////////////////////////////////

	hit_unique: assert property (@(posedge clk) disable iff (reset) $onehot0(hit_onehot))
		else $error("more than one entry matched the lookup address");

	// Only a dirty victim goes back to RAM
	wb_only: assert property (@(posedge clk) disable iff (reset)
			ram_we |-> state == cache_pkg::ST_WRITEBACK && victim_dirty)
		else $error("RAM write outside the writeback of a dirty victim");

endmodule

/* tb_cache_top.sv */
module tb_cache_top;

	localparam int N_WAYS     = 4;
	localparam int DRIVE_DLY  = 10;		// Input skew after the rising edge
	localparam int MAX_CYCLES = 8000;	// 772 accesses of at most 6 cycles, plus margin

	// Expected response of one access
	typedef struct packed {
		mem_pkg::addr_t addr;
		logic hit;
		logic wb;				// Miss with a dirty victim
		mem_pkg::data_t rdata;
	} expect_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic req = 1'b0;
	cache_pkg::access_t rw = cache_pkg::ACC_READ;
	mem_pkg::addr_t addr = '0;
	mem_pkg::data_t wdata = '0;
	logic busy, done, hit;
	mem_pkg::data_t rdata;

	logic [31:0] lcg_state = 32'h4572;
	mem_pkg::data_t model_mem [256];	// Coherent view of memory
	mem_pkg::addr_t lru_tags [$];		// Front is least recently used
	logic lru_dirty [$];
	expect_t exp_q [$];
	expect_t exp_e;
	int n_issued = 0;
	int n_checked = 0;
	int err_count = 0;
	int cycle_count = 0;
	int lat_count = 0;					// Negedges since req was seen
	logic active = 1'b0;
	logic last_hit;
	mem_pkg::data_t last_rdata;

	cache_top #(.N_WAYS(N_WAYS)) u_cache_top (
		.clk(clk), .reset(reset), .req(req), .rw(rw), .addr(addr), .wdata(wdata),
		.busy(busy), .done(done), .hit(hit), .rdata(rdata)
	);

	bind cache_top cache_assert #(.N_WAYS(N_WAYS)) u_cache_assert (
		.clk(clk), .reset(reset), .req(req), .busy(busy), .done(done),
		.hit_onehot(hit_onehot), .victim_dirty(victim_dirty), .ram_we(ram_we),
		.state(u_cache_ctrl.state)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////
	// Stimulus source and reference model
	////////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];			// Upper bits, longer period
	endfunction

	// LRU list model, invalid entries count as oldest
	function automatic expect_t predict_access(input cache_pkg::access_t kind,
			input mem_pkg::addr_t a, input mem_pkg::data_t d);
		expect_t e;
		int pos;
		logic was_dirty;
		e = '0;
		e.addr = a;
		pos = -1;
		was_dirty = 1'b0;
		for (int i = 0; i < lru_tags.size(); i++)
			if (lru_tags[i] == a)
				pos = i;
		if (pos >= 0) begin
			e.hit = 1'b1;
			was_dirty = lru_dirty[pos];
			lru_tags.delete(pos);			// Moves to MRU below
			lru_dirty.delete(pos);
		end else if (lru_tags.size() == N_WAYS) begin
			e.wb = lru_dirty[0];			// Victim goes back only if dirty
			void'(lru_tags.pop_front());
			void'(lru_dirty.pop_front());
		end
		lru_tags.push_back(a);
		lru_dirty.push_back(was_dirty || kind == cache_pkg::ACC_WRITE);
		if (kind == cache_pkg::ACC_WRITE)
			model_mem[a] = d;
		e.rdata = model_mem[a];				// Writes echo their word
		return e;
	endfunction

	////////////////////////////////////////////////////////////////////////
	// Checks and driver
	////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			err_count++;
			$display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string msg);
		err_count++;
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	// One request, returns once its response was checked
	task automatic issue_access(input cache_pkg::access_t kind, input mem_pkg::addr_t a,
			input mem_pkg::data_t d);
		exp_q.push_back(predict_access(kind, a, d));
		req   = 1'b1;
		rw    = kind;
		addr  = a;
		wdata = d;
		n_issued++;
		@(posedge clk);						// DUT samples req here
		#DRIVE_DLY;
		req = 1'b0;
		while (n_checked != n_issued)
			@(posedge clk);
		#DRIVE_DLY;
	endtask

	// Compare on the falling edge, away from input and state changes
	always @(negedge clk) begin
		if (!reset) begin
			if (active) begin
				lat_count++;
				if (!busy)
					report_failure($sformatf("busy went low before done, address %02h",
						exp_q[0].addr));
				if (done) begin
					exp_e = exp_q.pop_front();
					check_value($sformatf("hit, address %02h", exp_e.addr), hit, exp_e.hit);
					check_value($sformatf("rdata, address %02h", exp_e.addr), rdata,
						exp_e.rdata);
					if (exp_e.hit && lat_count != 2)
						report_failure($sformatf("Hit on %02h gave done after %0d cycles, not 2",
							exp_e.addr, lat_count));
					else if (!exp_e.hit && lat_count != (exp_e.wb ? 5 : 4))
						report_failure($sformatf("Miss on %02h gave done after %0d cycles",
							exp_e.addr, lat_count));
					last_hit   = hit;
					last_rdata = rdata;
					active     = 1'b0;
					n_checked++;
				end else if (lat_count >= 5)
					report_failure("No done within five cycles of a request");
			end else if (done)
				report_failure("done pulsed with no request outstanding");
			else if (req) begin
				if (busy)
					report_failure("Request driven while the cache was busy");
				active    = 1'b1;			// Sampled on the next rising edge
				lat_count = 0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, accesses did not finish", cycle_count);
			$display("Test failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////

	initial begin : main_seq
		mem_pkg::data_t vals [N_WAYS+1];
		mem_pkg::addr_t a;
		logic [7:0] r;
		repeat (10)
			@(posedge clk);
		#DRIVE_DLY;
		reset = 1'b0;

		// Whole address space written, RAM filled through writebacks
		for (int i = 0; i < 256; i++)
			issue_access(cache_pkg::ACC_WRITE, mem_pkg::addr_t'(i), next_random());

		// Write miss then read hit of the same word
		vals[0] = next_random();
		issue_access(cache_pkg::ACC_WRITE, 8'h3c, vals[0]);
		issue_access(cache_pkg::ACC_READ, 8'h3c, 8'h00);
		check_value("hit, reread of 3c", last_hit, 1'b1);
		check_value("rdata, reread of 3c", last_rdata, vals[0]);

		// One more distinct word than entries pushes the first out
		for (int i = 0; i <= N_WAYS; i++) begin
			vals[i] = next_random();
			issue_access(cache_pkg::ACC_WRITE, mem_pkg::addr_t'(16 * (i + 1)), vals[i]);
		end
		issue_access(cache_pkg::ACC_READ, 8'h10, 8'h00);
		check_value("hit, read of evicted 10", last_hit, 1'b0);
		check_value("rdata, read of evicted 10", last_rdata, vals[0]);	// From RAM

		// Re-touched oldest entry survives, next oldest goes
		for (int i = 0; i < N_WAYS; i++)
			issue_access(cache_pkg::ACC_READ, mem_pkg::addr_t'(8'h61 + i), 8'h00);
		issue_access(cache_pkg::ACC_READ, 8'h61, 8'h00);
		check_value("hit, retouch of 61", last_hit, 1'b1);
		issue_access(cache_pkg::ACC_READ, mem_pkg::addr_t'(8'h61 + N_WAYS), 8'h00);
		issue_access(cache_pkg::ACC_READ, 8'h61, 8'h00);
		check_value("hit, 61 after new miss", last_hit, 1'b1);
		issue_access(cache_pkg::ACC_READ, 8'h62, 8'h00);
		check_value("hit, 62 after new miss", last_hit, 1'b0);

		// Random mix over a 12-word window, more words than entries
		for (int i = 0; i < 500; i++) begin
			r = next_random();
			a = mem_pkg::addr_t'(8'ha0 + r % 8'd12);
			r = next_random();
			issue_access(r[7] ? cache_pkg::ACC_WRITE : cache_pkg::ACC_READ, a, next_random());
		end

		if (err_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* cache_top.f */
mem_pkg.sv
cache_pkg.sv
cache_way.sv
way_select.sv
cache_ctrl.sv
backing_ram.sv
cache_top.sv
cache_assert.sv
tb_cache_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cache_top
FILELIST  = cache_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failed
PASS_MSG  = Test passed

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

$(BIN): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
